/* source/idu_pkg.sv */
// decode stage shared types
`default_nettype none

package idu_pkg;

  typedef enum logic [5:0] {
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
    OP_SB, OP_SH, OP_SW, OP_SD,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    OP_ZERO_WORD,                                   // all-zero fetch word
    OP_INVALID
  } inst_op_e;

  typedef enum logic [4:0] {
    ALU_ADD      = 5'd0,
    ALU_SUB      = 5'd1,
    ALU_SLT      = 5'd2,
    ALU_SLTU     = 5'd3,
    ALU_XOR      = 5'd4,
    ALU_AND      = 5'd5,
    ALU_OR       = 5'd6,
    ALU_SLL      = 5'd7,
    ALU_SRL      = 5'd8,
    ALU_SRA      = 5'd9,
    ALU_COPY_IMM = 5'd15,                           // result = b
    ALU_NONE     = 5'd31
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_JAL  = 3'd1,
    BR_JALR = 3'd2,
    BR_EQ   = 3'd4,
    BR_NE   = 3'd5,
    BR_LT   = 3'd6,                                 // signedness from alu op
    BR_GE   = 3'd7
  } br_func_e;

  typedef enum logic [2:0] {
    MEM_LB   = 3'd0,
    MEM_LBU  = 3'd1,
    MEM_LH   = 3'd2,
    MEM_LHU  = 3'd3,
    MEM_LW   = 3'd4,
    MEM_LWU  = 3'd5,
    MEM_LD   = 3'd6,
    MEM_NONE = 3'd7
  } mem_op_e;

  typedef enum logic [1:0] {
    B_RS2  = 2'd0,
    B_IMM  = 2'd1,
    B_FOUR = 2'd2                                   // link address pc + 4
  } alu_b_src_e;

endpackage

`default_nettype wire

/* source/inst_classifier.sv */
// instruction classifier
`default_nettype none
`timescale 1ns/1ps

module inst_classifier (
  input  wire logic [31:0]     i_inst,
  output idu_pkg::inst_op_e    o_op
);

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_IMM_W  = 7'b0011011,
    OPC_OP     = 7'b0110011,
    OPC_OP_W   = 7'b0111011
  } opcode_e;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  always_comb begin
    o_op = idu_pkg::OP_INVALID;
    case (opcode)
      OPC_LUI:   o_op = idu_pkg::OP_LUI;
      OPC_AUIPC: o_op = idu_pkg::OP_AUIPC;
      OPC_JAL:   o_op = idu_pkg::OP_JAL;
      OPC_JALR:  if (funct3 == 3'b000) o_op = idu_pkg::OP_JALR;
      OPC_BRANCH: begin
        case (funct3)
          3'b000:  o_op = idu_pkg::OP_BEQ;
          3'b001:  o_op = idu_pkg::OP_BNE;
          3'b100:  o_op = idu_pkg::OP_BLT;
          3'b101:  o_op = idu_pkg::OP_BGE;
          3'b110:  o_op = idu_pkg::OP_BLTU;
          3'b111:  o_op = idu_pkg::OP_BGEU;
          default: ;
        endcase
      end
      OPC_LOAD: begin
        case (funct3)
          3'b000:  o_op = idu_pkg::OP_LB;
          3'b001:  o_op = idu_pkg::OP_LH;
          3'b010:  o_op = idu_pkg::OP_LW;
          3'b011:  o_op = idu_pkg::OP_LD;
          3'b100:  o_op = idu_pkg::OP_LBU;
          3'b101:  o_op = idu_pkg::OP_LHU;
          3'b110:  o_op = idu_pkg::OP_LWU;
          default: ;
        endcase
      end
      OPC_STORE: begin
        case (funct3)
          3'b000:  o_op = idu_pkg::OP_SB;
          3'b001:  o_op = idu_pkg::OP_SH;
          3'b010:  o_op = idu_pkg::OP_SW;
          3'b011:  o_op = idu_pkg::OP_SD;
          default: ;
        endcase
      end
      OPC_OP_IMM: begin
        case (funct3)
          3'b000:  o_op = idu_pkg::OP_ADDI;
          3'b010:  o_op = idu_pkg::OP_SLTI;
          3'b011:  o_op = idu_pkg::OP_SLTIU;
          3'b100:  o_op = idu_pkg::OP_XORI;
          3'b110:  o_op = idu_pkg::OP_ORI;
          3'b111:  o_op = idu_pkg::OP_ANDI;
          3'b001:  if (funct7[6:1] == 6'b000000) o_op = idu_pkg::OP_SLLI; // shamt is 6 bits
          3'b101: begin
            if (funct7[6:1] == 6'b000000)      o_op = idu_pkg::OP_SRLI;
            else if (funct7[6:1] == 6'b010000) o_op = idu_pkg::OP_SRAI;
          end
          default: ;
        endcase
      end
      OPC_IMM_W: begin
        case (funct3)
          3'b000:  o_op = idu_pkg::OP_ADDIW;
          3'b001:  if (funct7 == 7'b0000000) o_op = idu_pkg::OP_SLLIW;
          3'b101: begin
            if (funct7 == 7'b0000000)      o_op = idu_pkg::OP_SRLIW;
            else if (funct7 == 7'b0100000) o_op = idu_pkg::OP_SRAIW;
          end
          default: ;
        endcase
      end
      OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: o_op = idu_pkg::OP_ADD;
          10'b0100000_000: o_op = idu_pkg::OP_SUB;
          10'b0000000_001: o_op = idu_pkg::OP_SLL;
          10'b0000000_010: o_op = idu_pkg::OP_SLT;
          10'b0000000_011: o_op = idu_pkg::OP_SLTU;
          10'b0000000_100: o_op = idu_pkg::OP_XOR;
          10'b0000000_101: o_op = idu_pkg::OP_SRL;
          10'b0100000_101: o_op = idu_pkg::OP_SRA;
          10'b0000000_110: o_op = idu_pkg::OP_OR;
          10'b0000000_111: o_op = idu_pkg::OP_AND;
          default: ;                                // m extension lands here
        endcase
      end
      OPC_OP_W: begin
        case ({funct7, funct3})
          10'b0000000_000: o_op = idu_pkg::OP_ADDW;
          10'b0100000_000: o_op = idu_pkg::OP_SUBW;
          10'b0000000_001: o_op = idu_pkg::OP_SLLW;
          10'b0000000_101: o_op = idu_pkg::OP_SRLW;
          10'b0100000_101: o_op = idu_pkg::OP_SRAW;
          default: ;
        endcase
      end
      default: ;
    endcase
    if (i_inst == 32'b0) o_op = idu_pkg::OP_ZERO_WORD;  // bubble, not an error
  end

  always_comb begin
    if (!$isunknown(i_inst)) begin
      a_op_known: assert (!$isunknown(o_op));
    end
  end

endmodule

`default_nettype wire

/* source/imm_gen.sv */
// immediate generator
`default_nettype none
`timescale 1ns/1ps

module imm_gen #(
  parameter int XLEN = 64
) (
  input  wire logic [31:0]      i_inst,
  input  idu_pkg::inst_op_e     i_op,
  output logic [XLEN-1:0]       o_imm
);

  typedef enum logic [2:0] {FMT_NONE, FMT_I, FMT_S, FMT_B, FMT_U, FMT_J} fmt_e;

  fmt_e fmt;

  always_comb begin
    case (i_op)
      idu_pkg::OP_JALR,
      idu_pkg::OP_LB, idu_pkg::OP_LH, idu_pkg::OP_LW, idu_pkg::OP_LD,
      idu_pkg::OP_LBU, idu_pkg::OP_LHU, idu_pkg::OP_LWU,
      idu_pkg::OP_ADDI, idu_pkg::OP_SLTI, idu_pkg::OP_SLTIU, idu_pkg::OP_XORI,
      idu_pkg::OP_ORI, idu_pkg::OP_ANDI, idu_pkg::OP_SLLI, idu_pkg::OP_SRLI,
      idu_pkg::OP_SRAI, idu_pkg::OP_ADDIW, idu_pkg::OP_SLLIW, idu_pkg::OP_SRLIW,
      idu_pkg::OP_SRAIW:                                   fmt = FMT_I;
      idu_pkg::OP_SB, idu_pkg::OP_SH, idu_pkg::OP_SW, idu_pkg::OP_SD: fmt = FMT_S;
      idu_pkg::OP_BEQ, idu_pkg::OP_BNE, idu_pkg::OP_BLT,
      idu_pkg::OP_BGE, idu_pkg::OP_BLTU, idu_pkg::OP_BGEU: fmt = FMT_B;
      idu_pkg::OP_LUI, idu_pkg::OP_AUIPC:                  fmt = FMT_U;
      idu_pkg::OP_JAL:                                     fmt = FMT_J;
      default:                                             fmt = FMT_NONE;
    endcase
  end

  always_comb begin
    case (fmt)
      FMT_I:   o_imm = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
      FMT_S:   o_imm = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      FMT_B:   o_imm = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25],
                        i_inst[11:8], 1'b0};
      FMT_U:   o_imm = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
      FMT_J:   o_imm = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20],
                        i_inst[30:21], 1'b0};     // bit 20 comes from the sign fill
      default: o_imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* source/ctrl_gen.sv */
// decode control generator
`default_nettype none
`timescale 1ns/1ps

module ctrl_gen (
  input  idu_pkg::inst_op_e    i_op,
  output idu_pkg::alu_op_e     o_alu_op,
  output logic                 o_alu_a_src,
  output idu_pkg::alu_b_src_e  o_alu_b_src,
  output idu_pkg::br_func_e    o_br_func,
  output idu_pkg::mem_op_e     o_mem_op,
  output logic                 o_reg_wr,
  output logic                 o_mem_to_reg,
  output logic                 o_mem_wr,
  output logic                 o_mem_re,
  output logic                 o_word_cut,
  output logic                 o_invalid_inst
);

  logic is_load;
  logic is_store;
  logic is_rr;
  logic is_ri;
  logic is_jump;
  logic is_upper;

  assign is_load  = i_op inside {idu_pkg::OP_LB, idu_pkg::OP_LH, idu_pkg::OP_LW,
                                 idu_pkg::OP_LD, idu_pkg::OP_LBU, idu_pkg::OP_LHU,
                                 idu_pkg::OP_LWU};
  assign is_store = i_op inside {idu_pkg::OP_SB, idu_pkg::OP_SH, idu_pkg::OP_SW,
                                 idu_pkg::OP_SD};
  assign is_rr    = i_op inside {idu_pkg::OP_ADD, idu_pkg::OP_SUB, idu_pkg::OP_SLL,
                                 idu_pkg::OP_SLT, idu_pkg::OP_SLTU, idu_pkg::OP_XOR,
                                 idu_pkg::OP_SRL, idu_pkg::OP_SRA, idu_pkg::OP_OR,
                                 idu_pkg::OP_AND, idu_pkg::OP_ADDW, idu_pkg::OP_SUBW,
                                 idu_pkg::OP_SLLW, idu_pkg::OP_SRLW, idu_pkg::OP_SRAW};
  assign is_ri    = i_op inside {idu_pkg::OP_ADDI, idu_pkg::OP_SLTI, idu_pkg::OP_SLTIU,
                                 idu_pkg::OP_XORI, idu_pkg::OP_ORI, idu_pkg::OP_ANDI,
                                 idu_pkg::OP_SLLI, idu_pkg::OP_SRLI, idu_pkg::OP_SRAI,
                                 idu_pkg::OP_ADDIW, idu_pkg::OP_SLLIW, idu_pkg::OP_SRLIW,
                                 idu_pkg::OP_SRAIW};
  assign is_jump  = i_op inside {idu_pkg::OP_JAL, idu_pkg::OP_JALR};
  assign is_upper = i_op inside {idu_pkg::OP_LUI, idu_pkg::OP_AUIPC};

  always_comb begin
    case (i_op)
      idu_pkg::OP_ADD, idu_pkg::OP_ADDW, idu_pkg::OP_ADDI, idu_pkg::OP_ADDIW,
      idu_pkg::OP_AUIPC, idu_pkg::OP_JAL, idu_pkg::OP_JALR,
      idu_pkg::OP_LB, idu_pkg::OP_LH, idu_pkg::OP_LW, idu_pkg::OP_LD,
      idu_pkg::OP_LBU, idu_pkg::OP_LHU, idu_pkg::OP_LWU,
      idu_pkg::OP_SB, idu_pkg::OP_SH, idu_pkg::OP_SW, idu_pkg::OP_SD:
                                          o_alu_op = idu_pkg::ALU_ADD;
      idu_pkg::OP_SUB, idu_pkg::OP_SUBW,
      idu_pkg::OP_BEQ, idu_pkg::OP_BNE:   o_alu_op = idu_pkg::ALU_SUB;   // zero test
      idu_pkg::OP_SLT, idu_pkg::OP_SLTI,
      idu_pkg::OP_BLT, idu_pkg::OP_BGE:   o_alu_op = idu_pkg::ALU_SLT;
      idu_pkg::OP_SLTU, idu_pkg::OP_SLTIU,
      idu_pkg::OP_BLTU, idu_pkg::OP_BGEU: o_alu_op = idu_pkg::ALU_SLTU;
      idu_pkg::OP_XOR, idu_pkg::OP_XORI:  o_alu_op = idu_pkg::ALU_XOR;
      idu_pkg::OP_AND, idu_pkg::OP_ANDI:  o_alu_op = idu_pkg::ALU_AND;
      idu_pkg::OP_OR, idu_pkg::OP_ORI:    o_alu_op = idu_pkg::ALU_OR;
      idu_pkg::OP_SLL, idu_pkg::OP_SLLI,
      idu_pkg::OP_SLLIW, idu_pkg::OP_SLLW: o_alu_op = idu_pkg::ALU_SLL;
      idu_pkg::OP_SRL, idu_pkg::OP_SRLI,
      idu_pkg::OP_SRLIW, idu_pkg::OP_SRLW: o_alu_op = idu_pkg::ALU_SRL;
      idu_pkg::OP_SRA, idu_pkg::OP_SRAI,
      idu_pkg::OP_SRAIW, idu_pkg::OP_SRAW: o_alu_op = idu_pkg::ALU_SRA;
      idu_pkg::OP_LUI:                    o_alu_op = idu_pkg::ALU_COPY_IMM;
      default:                            o_alu_op = idu_pkg::ALU_NONE;
    endcase
  end

  always_comb begin
    case (i_op)
      idu_pkg::OP_JAL:                      o_br_func = idu_pkg::BR_JAL;
      idu_pkg::OP_JALR:                     o_br_func = idu_pkg::BR_JALR;
      idu_pkg::OP_BEQ:                      o_br_func = idu_pkg::BR_EQ;
      idu_pkg::OP_BNE:                      o_br_func = idu_pkg::BR_NE;
      idu_pkg::OP_BLT, idu_pkg::OP_BLTU:    o_br_func = idu_pkg::BR_LT;
      idu_pkg::OP_BGE, idu_pkg::OP_BGEU:    o_br_func = idu_pkg::BR_GE;
      default:                              o_br_func = idu_pkg::BR_NONE;
    endcase
  end

  always_comb begin
    case (i_op)
      idu_pkg::OP_LB, idu_pkg::OP_SB:       o_mem_op = idu_pkg::MEM_LB;   // stores take signed code
      idu_pkg::OP_LBU:                      o_mem_op = idu_pkg::MEM_LBU;
      idu_pkg::OP_LH, idu_pkg::OP_SH:       o_mem_op = idu_pkg::MEM_LH;
      idu_pkg::OP_LHU:                      o_mem_op = idu_pkg::MEM_LHU;
      idu_pkg::OP_LW, idu_pkg::OP_SW:       o_mem_op = idu_pkg::MEM_LW;
      idu_pkg::OP_LWU:                      o_mem_op = idu_pkg::MEM_LWU;
      idu_pkg::OP_LD, idu_pkg::OP_SD:       o_mem_op = idu_pkg::MEM_LD;
      default:                              o_mem_op = idu_pkg::MEM_NONE;
    endcase
  end

  always_comb begin
    if (is_jump)                                 o_alu_b_src = idu_pkg::B_FOUR;
    else if (is_ri || is_load || is_store || is_upper) o_alu_b_src = idu_pkg::B_IMM;
    else                                         o_alu_b_src = idu_pkg::B_RS2;
  end

  assign o_alu_a_src    = is_jump || (i_op == idu_pkg::OP_AUIPC);  // 1 selects pc
  assign o_reg_wr       = is_rr || is_ri || is_load || is_jump || is_upper;
  assign o_mem_to_reg   = is_load;
  assign o_mem_re       = is_load;
  assign o_mem_wr       = is_store;
  assign o_word_cut     = i_op inside {idu_pkg::OP_ADDIW, idu_pkg::OP_SLLIW,
                                       idu_pkg::OP_SRLIW, idu_pkg::OP_SRAIW,
                                       idu_pkg::OP_ADDW, idu_pkg::OP_SUBW,
                                       idu_pkg::OP_SLLW, idu_pkg::OP_SRLW,
                                       idu_pkg::OP_SRAW};
  assign o_invalid_inst = (i_op == idu_pkg::OP_INVALID);

  always_comb begin
    a_mem_excl: assert (!(o_mem_wr && o_mem_re));
  end

endmodule

`default_nettype wire

/* source/gpr_file.sv */
// general purpose register file
`default_nettype none
`timescale 1ns/1ps

module gpr_file #(
  parameter int XLEN       = 64,
  parameter int REG_ADDR_W = 5
) (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst_n,
  input  wire logic                  i_wen,
  input  wire logic [REG_ADDR_W-1:0] i_waddr,
  input  wire logic [REG_ADDR_W-1:0] i_raddr1,
  input  wire logic [REG_ADDR_W-1:0] i_raddr2,
  input  wire logic [XLEN-1:0]       i_wdata,
  output logic      [XLEN-1:0]       o_rdata1,
  output logic      [XLEN-1:0]       o_rdata2
);

  localparam int NREGS = 1 << REG_ADDR_W;

  logic [XLEN-1:0] regs [NREGS];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin  // x0 writes dropped
      regs[i_waddr] <= i_wdata;
    end
  end

  // no bypass, new data shows the cycle after the write
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  a_x0_rd1: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_raddr1 != '0) || (o_rdata1 == '0));
  a_x0_rd2: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_raddr2 != '0) || (o_rdata2 == '0));

endmodule

`default_nettype wire

/* source/idu_top.sv */
// instruction decode unit
`default_nettype none
`timescale 1ns/1ps

module idu_top #(
  parameter int XLEN       = 64,
  parameter int REG_ADDR_W = 5
) (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst_n,
  input  wire logic [31:0]           i_inst,
  input  wire logic                  i_rf_wen,
  input  wire logic [REG_ADDR_W-1:0] i_rf_waddr,
  input  wire logic [XLEN-1:0]       i_rf_wdata,
  output logic      [REG_ADDR_W-1:0] o_rd,
  output logic      [XLEN-1:0]       o_rs1_data,
  output logic      [XLEN-1:0]       o_rs2_data,
  output logic      [XLEN-1:0]       o_imm,
  output idu_pkg::alu_op_e           o_alu_op,
  output logic                       o_alu_a_src,
  output idu_pkg::alu_b_src_e        o_alu_b_src,
  output idu_pkg::br_func_e          o_br_func,
  output idu_pkg::mem_op_e           o_mem_op,
  output logic                       o_reg_wr,
  output logic                       o_mem_to_reg,
  output logic                       o_mem_wr,
  output logic                       o_mem_re,
  output logic                       o_word_cut,
  output logic                       o_invalid_inst
);

  idu_pkg::inst_op_e     op;
  logic [REG_ADDR_W-1:0] rs1;
  logic [REG_ADDR_W-1:0] rs2;

  assign rs1  = i_inst[15 +: REG_ADDR_W];
  assign rs2  = i_inst[20 +: REG_ADDR_W];
  assign o_rd = i_inst[7 +: REG_ADDR_W];

  inst_classifier u_classifier (
    .i_inst (i_inst),
    .o_op   (op)
  );

  imm_gen #(.XLEN(XLEN)) u_imm (
    .i_inst (i_inst),
    .i_op   (op),
    .o_imm  (o_imm)
  );

  ctrl_gen u_ctrl (
    .i_op           (op),
    .o_alu_op       (o_alu_op),
    .o_alu_a_src    (o_alu_a_src),
    .o_alu_b_src    (o_alu_b_src),
    .o_br_func      (o_br_func),
    .o_mem_op       (o_mem_op),
    .o_reg_wr       (o_reg_wr),
    .o_mem_to_reg   (o_mem_to_reg),
    .o_mem_wr       (o_mem_wr),
    .o_mem_re       (o_mem_re),
    .o_word_cut     (o_word_cut),
    .o_invalid_inst (o_invalid_inst)
  );

  gpr_file #(.XLEN(XLEN), .REG_ADDR_W(REG_ADDR_W)) u_gprs (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_wen    (i_rf_wen),
    .i_waddr  (i_rf_waddr),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wdata  (i_rf_wdata),
    .o_rdata1 (o_rs1_data),
    .o_rdata2 (o_rs2_data)
  );

endmodule

`default_nettype wire

/* verif/tb_inst_enc.svh */
// instruction encoders
`ifndef TB_INST_ENC_SVH
`define TB_INST_ENC_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] opc);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
endfunction

// bit 0 of a branch offset is not encoded
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [6:0] opc);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opc};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opc};  // scrambled jal layout
endfunction

`endif

/* verif/tb_idu.sv */
// decode stage testbench
`default_nettype none
`timescale 1ns/1ps

module tb_idu;

  `include "tb_inst_enc.svh"

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 1;
  localparam int RESET_CYCLES = 10;
  localparam int N_RAND       = 8;
  localparam int TOTAL_CYCLES = (RESET_CYCLES + 1) + (3 * N_RAND + 2) + (6 * N_RAND)
                                + 30 + 11 + 8 + (N_RAND + 5);

  localparam logic [6:0] OPC_LUI = 7'h37, OPC_AUIPC = 7'h17, OPC_JAL = 7'h6f,
                         OPC_JALR = 7'h67, OPC_BRANCH = 7'h63, OPC_LOAD = 7'h03,
                         OPC_STORE = 7'h23, OPC_OP_IMM = 7'h13, OPC_IMM_W = 7'h1b,
                         OPC_OP = 7'h33, OPC_OP_W = 7'h3b, OPC_SYSTEM = 7'h73;
  localparam logic [4:0] A_ADD = 5'd0, A_SUB = 5'd1, A_SLT = 5'd2, A_SLTU = 5'd3,
                         A_XOR = 5'd4, A_AND = 5'd5, A_OR = 5'd6, A_SLL = 5'd7,
                         A_SRL = 5'd8, A_SRA = 5'd9, A_COPY = 5'd15;
  localparam logic [1:0] B_RS2 = 2'd0, B_IMM = 2'd1, B_FOUR = 2'd2;
  localparam logic [2:0] BR_NONE = 3'd0, BR_JAL = 3'd1, BR_JALR = 3'd2, BR_EQ = 3'd4,
                         BR_NE = 3'd5, BR_LT = 3'd6, BR_GE = 3'd7;
  localparam logic [4:0] X5 = 5'd5, X6 = 5'd6, X7 = 5'd7;

  logic        clk;
  logic        rst_n;
  logic [31:0] inst;
  logic        rf_wen;
  logic [4:0]  rf_waddr;
  logic [63:0] rf_wdata;
  logic [4:0]  rd;
  logic [63:0] rs1_data;
  logic [63:0] rs2_data;
  logic [63:0] imm;
  logic [4:0]  alu_op;
  logic        alu_a_src;
  logic [1:0]  alu_b_src;
  logic [2:0]  br_func;
  logic [2:0]  mem_op;
  logic        reg_wr;
  logic        mem_to_reg;
  logic        mem_wr;
  logic        mem_re;
  logic        word_cut;
  logic        invalid_inst;
  logic [31:0] rng_state = 32'd26;

  idu_top #(.XLEN(64), .REG_ADDR_W(5)) u_dut (
    .i_clk (clk), .i_rst_n (rst_n), .i_inst (inst),
    .i_rf_wen (rf_wen), .i_rf_waddr (rf_waddr), .i_rf_wdata (rf_wdata),
    .o_rd (rd), .o_rs1_data (rs1_data), .o_rs2_data (rs2_data), .o_imm (imm),
    .o_alu_op (alu_op), .o_alu_a_src (alu_a_src), .o_alu_b_src (alu_b_src),
    .o_br_func (br_func), .o_mem_op (mem_op), .o_reg_wr (reg_wr),
    .o_mem_to_reg (mem_to_reg), .o_mem_wr (mem_wr), .o_mem_re (mem_re),
    .o_word_cut (word_cut), .o_invalid_inst (invalid_inst)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(2 * TOTAL_CYCLES * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", 2 * TOTAL_CYCLES);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic bit known_opcode(input logic [6:0] opc);
    return opc inside {OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH, OPC_LOAD,
                       OPC_STORE, OPC_OP_IMM, OPC_IMM_W, OPC_OP, OPC_OP_W};
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (act !== exp) begin
      $display("Fail %s expected 0x%h actual 0x%h", name, exp, act);
      $display("Simulation failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // new inputs after the edge, outputs sampled at the falling edge
  task automatic apply(input logic [31:0] x);
    @(posedge clk);
    #DRIVE_DELAY;
    rf_wen = 1'b0;
    inst   = x;
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [4:0] a, input logic [63:0] d);
    @(posedge clk);
    #DRIVE_DELAY;
    rf_wen   = 1'b1;
    rf_waddr = a;
    rf_wdata = d;
  endtask

  task automatic test_regfile();
    logic [31:0] r;
    logic [4:0]  a;
    logic [4:0]  prev;
    logic [63:0] d;
    logic [63:0] model [32];
    for (int i = 0; i < 32; i++) begin
      model[i] = '0;
    end
    repeat (N_RAND) begin
      r = next_rand();
      apply(enc_r(7'h00, r[9:5], r[4:0], 3'd0, 5'd1, OPC_OP));
      check_value("rf reset rs1", 64'd0, rs1_data);
      check_value("rf reset rs2", 64'd0, rs2_data);
    end
    prev = 5'd1;
    repeat (N_RAND) begin
      r = next_rand();
      a = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
      d = {next_rand(), next_rand()};
      write_reg(a, d);
      model[a] = d;
      apply(enc_r(7'h00, prev, a, 3'd0, 5'd1, OPC_OP));  // read back next cycle
      check_value("rf write rs1", model[a], rs1_data);
      check_value("rf write rs2", model[prev], rs2_data);
      prev = a;
    end
    write_reg(5'd0, {r, ~r});
    apply(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd1, OPC_OP));
    check_value("rf x0 rs1", 64'd0, rs1_data);
    check_value("rf x0 rs2", 64'd0, rs2_data);
  endtask

  task automatic test_immediates();
    logic [31:0] r;
    logic [31:0] r2;
    logic [11:0] i12;
    logic [12:0] b13;
    logic [19:0] u20;
    logic [20:0] j21;
    repeat (N_RAND) begin
      r   = next_rand();
      r2  = next_rand();
      i12 = r[11:0];
      b13 = {r[23:12], 1'b0};
      u20 = r[31:12];
      j21 = {r2[20:1], 1'b0};
      apply(enc_i(i12, X5, 3'd0, X7, OPC_OP_IMM));
      check_value("imm I", {{52{i12[11]}}, i12}, imm);
      apply(enc_s(i12, X6, X5, 3'd3, OPC_STORE));
      check_value("imm S", {{52{i12[11]}}, i12}, imm);
      apply(enc_b(b13, X6, X5, 3'd1, OPC_BRANCH));
      check_value("imm B", {{51{b13[12]}}, b13}, imm);
      apply(enc_u(u20, X7, OPC_LUI));
      check_value("imm U", {{32{u20[19]}}, u20, 12'h000}, imm);
      apply(enc_j(j21, X7, OPC_JAL));
      check_value("imm J", {{43{j21[20]}}, j21}, imm);
      apply(enc_r(7'h00, r2[9:5], r2[4:0], 3'd0, X7, OPC_OP));
      check_value("imm R", 64'd0, imm);
    end
  endtask

  task automatic check_arith(input string name, input logic [31:0] x, input logic [4:0] alu,
                             input logic a_src, input logic [1:0] b_src, input logic wc);
    apply(x);
    check_value({name, " alu"}, 64'(alu), 64'(alu_op));
    check_value({name, " a src"}, 64'(a_src), 64'(alu_a_src));
    check_value({name, " b src"}, 64'(b_src), 64'(alu_b_src));
    check_value({name, " rd"}, 64'(X7), 64'(rd));
    check_value({name, " reg wr"}, 64'd1, 64'(reg_wr));
    check_value({name, " word cut"}, 64'(wc), 64'(word_cut));
    check_value({name, " mem strobes"}, 64'd0, 64'({mem_re, mem_wr, invalid_inst}));
  endtask

  task automatic test_arith();
    check_arith("add", enc_r(7'h00, X6, X5, 3'd0, X7, OPC_OP), A_ADD, 1'b0, B_RS2, 1'b0);
    check_arith("sub", enc_r(7'h20, X6, X5, 3'd0, X7, OPC_OP), A_SUB, 1'b0, B_RS2, 1'b0);
    check_arith("sll", enc_r(7'h00, X6, X5, 3'd1, X7, OPC_OP), A_SLL, 1'b0, B_RS2, 1'b0);
    check_arith("slt", enc_r(7'h00, X6, X5, 3'd2, X7, OPC_OP), A_SLT, 1'b0, B_RS2, 1'b0);
    check_arith("sltu", enc_r(7'h00, X6, X5, 3'd3, X7, OPC_OP), A_SLTU, 1'b0, B_RS2, 1'b0);
    check_arith("xor", enc_r(7'h00, X6, X5, 3'd4, X7, OPC_OP), A_XOR, 1'b0, B_RS2, 1'b0);
    check_arith("srl", enc_r(7'h00, X6, X5, 3'd5, X7, OPC_OP), A_SRL, 1'b0, B_RS2, 1'b0);
    check_arith("sra", enc_r(7'h20, X6, X5, 3'd5, X7, OPC_OP), A_SRA, 1'b0, B_RS2, 1'b0);
    check_arith("or", enc_r(7'h00, X6, X5, 3'd6, X7, OPC_OP), A_OR, 1'b0, B_RS2, 1'b0);
    check_arith("and", enc_r(7'h00, X6, X5, 3'd7, X7, OPC_OP), A_AND, 1'b0, B_RS2, 1'b0);
    check_arith("addi", enc_i(12'h801, X5, 3'd0, X7, OPC_OP_IMM), A_ADD, 1'b0, B_IMM, 1'b0);
    check_arith("slti", enc_i(12'h123, X5, 3'd2, X7, OPC_OP_IMM), A_SLT, 1'b0, B_IMM, 1'b0);
    check_arith("sltiu", enc_i(12'hfff, X5, 3'd3, X7, OPC_OP_IMM), A_SLTU, 1'b0, B_IMM, 1'b0);
    check_arith("xori", enc_i(12'h0f0, X5, 3'd4, X7, OPC_OP_IMM), A_XOR, 1'b0, B_IMM, 1'b0);
    check_arith("ori", enc_i(12'h00f, X5, 3'd6, X7, OPC_OP_IMM), A_OR, 1'b0, B_IMM, 1'b0);
    check_arith("andi", enc_i(12'h7ff, X5, 3'd7, X7, OPC_OP_IMM), A_AND, 1'b0, B_IMM, 1'b0);
    check_arith("slli", enc_i(12'h02d, X5, 3'd1, X7, OPC_OP_IMM), A_SLL, 1'b0, B_IMM, 1'b0);
    check_arith("srli", enc_i(12'h02d, X5, 3'd5, X7, OPC_OP_IMM), A_SRL, 1'b0, B_IMM, 1'b0);
    check_arith("srai", enc_i(12'h42d, X5, 3'd5, X7, OPC_OP_IMM), A_SRA, 1'b0, B_IMM, 1'b0);
    check_arith("addiw", enc_i(12'h900, X5, 3'd0, X7, OPC_IMM_W), A_ADD, 1'b0, B_IMM, 1'b1);
    check_arith("slliw", enc_i(12'h01f, X5, 3'd1, X7, OPC_IMM_W), A_SLL, 1'b0, B_IMM, 1'b1);
    check_arith("srliw", enc_i(12'h01f, X5, 3'd5, X7, OPC_IMM_W), A_SRL, 1'b0, B_IMM, 1'b1);
    check_arith("sraiw", enc_i(12'h41f, X5, 3'd5, X7, OPC_IMM_W), A_SRA, 1'b0, B_IMM, 1'b1);
    check_arith("addw", enc_r(7'h00, X6, X5, 3'd0, X7, OPC_OP_W), A_ADD, 1'b0, B_RS2, 1'b1);
    check_arith("subw", enc_r(7'h20, X6, X5, 3'd0, X7, OPC_OP_W), A_SUB, 1'b0, B_RS2, 1'b1);
    check_arith("sllw", enc_r(7'h00, X6, X5, 3'd1, X7, OPC_OP_W), A_SLL, 1'b0, B_RS2, 1'b1);
    check_arith("srlw", enc_r(7'h00, X6, X5, 3'd5, X7, OPC_OP_W), A_SRL, 1'b0, B_RS2, 1'b1);
    check_arith("sraw", enc_r(7'h20, X6, X5, 3'd5, X7, OPC_OP_W), A_SRA, 1'b0, B_RS2, 1'b1);
    check_arith("lui", enc_u(20'h80001, X7, OPC_LUI), A_COPY, 1'b0, B_IMM, 1'b0);
    check_arith("auipc", enc_u(20'h00042, X7, OPC_AUIPC), A_ADD, 1'b1, B_IMM, 1'b0);
  endtask

  task automatic check_mem(input string name, input logic [31:0] x, input logic [2:0] mop,
                           input logic ld);
    apply(x);
    check_value({name, " mem op"}, 64'(mop), 64'(mem_op));
    check_value({name, " mem re"}, 64'(ld), 64'(mem_re));
    check_value({name, " mem to reg"}, 64'(ld), 64'(mem_to_reg));
    check_value({name, " reg wr"}, 64'(ld), 64'(reg_wr));
    check_value({name, " mem wr"}, 64'(!ld), 64'(mem_wr));
    check_value({name, " alu"}, 64'(A_ADD), 64'(alu_op));
    check_value({name, " b src"}, 64'(B_IMM), 64'(alu_b_src));
  endtask

  task automatic test_mem();
    // codes lb 0, lbu 1, lh 2, lhu 3, lw 4, lwu 5, ld 6
    check_mem("lb", enc_i(12'h7f0, X5, 3'd0, X7, OPC_LOAD), 3'd0, 1'b1);
    check_mem("lh", enc_i(12'h010, X5, 3'd1, X7, OPC_LOAD), 3'd2, 1'b1);
    check_mem("lw", enc_i(12'h804, X5, 3'd2, X7, OPC_LOAD), 3'd4, 1'b1);
    check_mem("ld", enc_i(12'h008, X5, 3'd3, X7, OPC_LOAD), 3'd6, 1'b1);
    check_mem("lbu", enc_i(12'h001, X5, 3'd4, X7, OPC_LOAD), 3'd1, 1'b1);
    check_mem("lhu", enc_i(12'h002, X5, 3'd5, X7, OPC_LOAD), 3'd3, 1'b1);
    check_mem("lwu", enc_i(12'hffc, X5, 3'd6, X7, OPC_LOAD), 3'd5, 1'b1);
    check_mem("sb", enc_s(12'h018, X6, X5, 3'd0, OPC_STORE), 3'd0, 1'b0);
    check_mem("sh", enc_s(12'h81a, X6, X5, 3'd1, OPC_STORE), 3'd2, 1'b0);
    check_mem("sw", enc_s(12'h01c, X6, X5, 3'd2, OPC_STORE), 3'd4, 1'b0);
    check_mem("sd", enc_s(12'hff8, X6, X5, 3'd3, OPC_STORE), 3'd6, 1'b0);
  endtask

  task automatic check_branch(input string name, input logic [31:0] x,
                              input logic [2:0] br, input logic [4:0] alu);
    apply(x);
    check_value({name, " br func"}, 64'(br), 64'(br_func));
    check_value({name, " alu"}, 64'(alu), 64'(alu_op));
    check_value({name, " a src"}, 64'd0, 64'(alu_a_src));
    check_value({name, " b src"}, 64'(B_RS2), 64'(alu_b_src));
    check_value({name, " strobes"}, 64'd0, 64'({reg_wr, mem_re, mem_wr}));
  endtask

  task automatic check_jump(input string name, input logic [31:0] x, input logic [2:0] br);
    apply(x);
    check_value({name, " br func"}, 64'(br), 64'(br_func));
    check_value({name, " a src"}, 64'd1, 64'(alu_a_src));
    check_value({name, " b src"}, 64'(B_FOUR), 64'(alu_b_src));
    check_value({name, " reg wr"}, 64'd1, 64'(reg_wr));
  endtask

  task automatic test_branches();
    check_branch("beq", enc_b(13'h0010, X6, X5, 3'd0, OPC_BRANCH), BR_EQ, A_SUB);
    check_branch("bne", enc_b(13'h1ff0, X6, X5, 3'd1, OPC_BRANCH), BR_NE, A_SUB);
    check_branch("blt", enc_b(13'h0800, X6, X5, 3'd4, OPC_BRANCH), BR_LT, A_SLT);
    check_branch("bge", enc_b(13'h0004, X6, X5, 3'd5, OPC_BRANCH), BR_GE, A_SLT);
    check_branch("bltu", enc_b(13'h1000, X6, X5, 3'd6, OPC_BRANCH), BR_LT, A_SLTU);
    check_branch("bgeu", enc_b(13'h0102, X6, X5, 3'd7, OPC_BRANCH), BR_GE, A_SLTU);
    check_jump("jal", enc_j(21'h000800, X7, OPC_JAL), BR_JAL);
    check_jump("jalr", enc_i(12'h010, X5, 3'd0, X7, OPC_JALR), BR_JALR);
  endtask

  task automatic check_strobes(input string name, input logic [31:0] x, input logic inv);
    apply(x);
    check_value({name, " invalid"}, 64'(inv), 64'(invalid_inst));
    check_value({name, " strobes"}, 64'd0, 64'({reg_wr, mem_to_reg, mem_re, mem_wr}));
    check_value({name, " br func"}, 64'(BR_NONE), 64'(br_func));
  endtask

  task automatic test_invalid();
    logic [31:0] r;
    repeat (N_RAND) begin
      do begin
        r = next_rand();
      end while (known_opcode(r[6:0]) || (r == 32'd0));
      check_strobes("rand opcode", r, 1'b1);
    end
    check_strobes("mul", enc_r(7'h01, X6, X5, 3'd0, X7, OPC_OP), 1'b1);
    check_strobes("divw", enc_r(7'h01, X6, X5, 3'd4, X7, OPC_OP_W), 1'b1);
    check_strobes("csrrw", enc_i(12'h340, X5, 3'd1, 5'd0, OPC_SYSTEM), 1'b1);
    check_strobes("ecall", enc_i(12'h000, 5'd0, 3'd0, 5'd0, OPC_SYSTEM), 1'b1);
    check_strobes("zero word", 32'd0, 1'b0);  // bubble, not flagged
  endtask

  initial begin
    rst_n    = 1'b0;
    inst     = '0;
    rf_wen   = 1'b0;
    rf_waddr = '0;
    rf_wdata = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    test_regfile();
    test_immediates();
    test_arith();
    test_mem();
    test_branches();
    test_invalid();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+verif
source/idu_pkg.sv
source/inst_classifier.sv
source/imm_gen.sv
source/ctrl_gen.sv
source/gpr_file.sv
source/idu_top.sv
verif/tb_idu.sv

/* run_sim.sh */
#!/bin/sh
# build the decode stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_idu \
  -Mdir obj_dir -o sim_idu \
  -f sources.f

./obj_dir/sim_idu 2>&1 | tee sim.log

if grep -q "Simulation completed successfully" sim.log; then
  echo "run_sim: PASS"
  exit 0
else
  echo "run_sim: FAIL"
  exit 1
fi
